/* verilog/commit_pkg.sv */
// ====================
// Commit stage package
// Shared widths, result packets and sizes of the commit stage
// ====================

package commit_pkg;

    // ====================
    // Widths and sizes
    // ====================

    // Result word width
    localparam int DATA_W = 32;

    // Architectural register index, register 0 is hard-wired to zero
    localparam int REG_ADDR_W = 5;

    // Number of architectural registers covered by the forwarding memories
    localparam int NUM_REGS = 1 << REG_ADDR_W;

    // Reorder tags are issued in program order and wrap at 64
    localparam int ROB_TAG_W = 6;

    // Integer, floating point and load/store units, one buffer each
    localparam int NUM_UNITS = 3;

    // Default entries per commit buffer, any power of two works
    localparam int BUFFER_DEPTH = 8;

    // Source operands that the issue stage can ask to forward
    localparam int NUM_SRC = 2;

    // ====================
    // Types
    // ====================

    typedef logic [DATA_W-1:0]     data_word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ROB_TAG_W-1:0]  rob_tag_t;

    // One bit per execution unit
    typedef logic [NUM_UNITS-1:0] unit_mask_t;

    // Per source operand vectors of the forwarding path
    typedef reg_addr_t  [NUM_SRC-1:0] src_addr_t;
    typedef data_word_t [NUM_SRC-1:0] src_data_t;
    typedef logic       [NUM_SRC-1:0] src_valid_t;

    // Destination and position in program order of an instruction
    typedef struct packed {
        reg_addr_t reg_dest;
        rob_tag_t  rob_tag;
    } instr_packet_t;

    // What an execution unit delivers
    typedef struct packed {
        data_word_t    result;
        instr_packet_t ipacket;
    } exec_result_t;

    // Register file write port
    typedef struct packed {
        reg_addr_t  reg_dest;
        data_word_t data;
    } writeback_t;

    // Arrays indexed by unit
    typedef exec_result_t [NUM_UNITS-1:0] unit_results_t;
    typedef src_data_t    [NUM_UNITS-1:0] unit_fwd_data_t;
    typedef src_valid_t   [NUM_UNITS-1:0] unit_fwd_valid_t;

endpackage : commit_pkg

/* verilog/commit_buffer.sv */
// ====================
// Commit buffer
// Per-unit result FIFO with a forwarding memory indexed by destination
// ====================

`timescale 1ns/100ps

module commit_buffer #(
    parameter int BUFFER_DEPTH = commit_pkg::BUFFER_DEPTH
) (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     flush_i,

    // Push from the dispatcher and pop from the arbiter
    input  logic                     write_i,
    input  logic                     read_i,
    input  commit_pkg::exec_result_t entry_i,
    output commit_pkg::exec_result_t entry_o,

    // Another buffer took a newer result for this register
    input  logic                     invalidate_i,
    input  commit_pkg::reg_addr_t    invalid_reg_i,

    // Forwarding lookup for the issue stage
    input  commit_pkg::src_addr_t    forward_src_i,
    output commit_pkg::src_data_t    forward_result_o,
    output commit_pkg::src_valid_t   forward_valid_o,

    output logic                     full_o,
    output logic                     empty_o
);

    // ====================
    // FIFO control
    // ====================

    // Depth is a power of two so the pointers wrap on their own
    logic [$clog2(BUFFER_DEPTH)-1:0] write_ptr;
    logic [$clog2(BUFFER_DEPTH)-1:0] read_ptr;
    logic [$clog2(BUFFER_DEPTH)-1:0] write_ptr_next;
    logic [$clog2(BUFFER_DEPTH)-1:0] read_ptr_next;

    assign write_ptr_next = write_ptr + 1'b1;
    assign read_ptr_next  = read_ptr + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            full_o    <= 1'b0;
            empty_o   <= 1'b1;
        end else begin
            if (write_i) begin
                write_ptr <= write_ptr_next;
            end
            if (read_i) begin
                read_ptr <= read_ptr_next;
            end

            // Flags only move when exactly one side is active
            case ({write_i, read_i})
                2'b10: begin
                    empty_o <= 1'b0;
                    full_o  <= (write_ptr_next == read_ptr);
                end
                2'b01: begin
                    full_o  <= 1'b0;
                    empty_o <= (read_ptr_next == write_ptr);
                end
                default: begin
                    full_o  <= full_o;
                    empty_o <= empty_o;
                end
            endcase
        end
    end

    // ====================
    // Entry storage
    // ====================

    commit_pkg::exec_result_t entry_mem [BUFFER_DEPTH];

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            entry_mem[write_ptr] <= entry_i;
        end
    end

    // Head is read combinationally so the arbiter can match its tag in the same cycle
    assign entry_o = entry_mem[read_ptr];

    // ====================
    // Forwarding memory
    // ====================

    // Newest result per destination and the tag of the instruction that wrote it
    commit_pkg::data_word_t            fwd_mem [commit_pkg::NUM_REGS];
    commit_pkg::rob_tag_t              tag_mem [commit_pkg::NUM_REGS];
    logic [commit_pkg::NUM_REGS-1:0]   fwd_valid;

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            fwd_mem[entry_i.ipacket.reg_dest] <= entry_i.result;
            tag_mem[entry_i.ipacket.reg_dest] <= entry_i.ipacket.rob_tag;
        end
    end

    // A write of the same register in the pop cycle is newer than the head,
    // so the set comes last and wins over both clears
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            fwd_valid <= '0;
        end else begin
            // The committing instruction still owns the entry, the register file now has it
            if (read_i && (tag_mem[entry_o.ipacket.reg_dest] == entry_o.ipacket.rob_tag)) begin
                fwd_valid[entry_o.ipacket.reg_dest] <= 1'b0;
            end
            // The copy here is older than the one just taken by another buffer
            if (invalidate_i) begin
                fwd_valid[invalid_reg_i] <= 1'b0;
            end
            if (write_i) begin
                fwd_valid[entry_i.ipacket.reg_dest] <= 1'b1;
            end
        end
    end

    // Register 0 always forwards zero
    always_comb begin
        for (int s = 0; s < commit_pkg::NUM_SRC; s++) begin
            if (forward_src_i[s] == '0) begin
                forward_result_o[s] = '0;
                forward_valid_o[s]  = 1'b1;
            end else begin
                forward_result_o[s] = fwd_mem[forward_src_i[s]];
                forward_valid_o[s]  = fwd_valid[forward_src_i[s]];
            end
        end
    end

endmodule : commit_buffer

/* verilog/result_dispatch.sv */
// ====================
// Result dispatcher
// Takes one unit result per cycle by fixed priority and stalls the rest
// ====================

`timescale 1ns/100ps

module result_dispatch (
    input  commit_pkg::unit_mask_t    unit_valid_i,
    input  commit_pkg::unit_results_t unit_result_i,
    input  commit_pkg::unit_mask_t    full_i,

    output commit_pkg::unit_mask_t    unit_stall_o,

    // Buffer write strobes and the selected result
    output commit_pkg::unit_mask_t    write_o,
    output commit_pkg::exec_result_t  entry_o,

    // Invalidation of the forwarded copy in every other buffer
    output commit_pkg::unit_mask_t    invalidate_o,
    output commit_pkg::reg_addr_t     invalid_reg_o
);

    // High once a lower-index unit has been granted
    logic granted;

    // ====================
    // Priority select
    // ====================

    // Unit 0 has the highest priority, a unit with a full buffer is skipped
    always_comb begin
        granted = 1'b0;
        write_o = '0;
        entry_o = '0;
        for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
            if (unit_valid_i[u] && !full_i[u] && !granted) begin
                write_o[u] = 1'b1;
                entry_o    = unit_result_i[u];
                granted    = 1'b1;
            end
        end
    end

    // A full buffer holds its unit, and a valid unit that lost arbitration waits
    always_comb begin
        for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
            unit_stall_o[u] = full_i[u] || (unit_valid_i[u] && !write_o[u]);
        end
    end

    // ====================
    // Invalidation
    // ====================

    // The written buffer now holds the newest value of that register
    assign invalidate_o  = granted ? ~write_o : '0;
    assign invalid_reg_o = entry_o.ipacket.reg_dest;

endmodule : result_dispatch

/* verilog/forward_select.sv */
// ====================
// Forward selector
// Merges the buffers' forwarding answers per source operand
// ====================

`timescale 1ns/100ps

module forward_select (
    input  commit_pkg::unit_fwd_data_t  buf_result_i,
    input  commit_pkg::unit_fwd_valid_t buf_valid_i,

    output commit_pkg::src_data_t       fwd_result_o,
    output commit_pkg::src_valid_t      fwd_valid_o
);

    // ====================
    // AND-OR merge
    // ====================

    // Invalidation leaves at most one buffer valid for a register,
    // so masking each answer with its valid and ORing them is a one-hot mux
    // (register 0 is valid everywhere but all answers are zero)
    always_comb begin
        fwd_result_o = '0;
        fwd_valid_o  = '0;
        for (int s = 0; s < commit_pkg::NUM_SRC; s++) begin
            for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
                if (buf_valid_i[u][s]) begin
                    fwd_result_o[s] = fwd_result_o[s] | buf_result_i[u][s];
                end
                fwd_valid_o[s] = fwd_valid_o[s] | buf_valid_i[u][s];
            end
        end
    end

endmodule : forward_select

/* verilog/commit_arbiter.sv */
// ====================
// Commit arbiter
// Pops results in reorder tag order and drives the register file write
// ====================

`timescale 1ns/100ps

module commit_arbiter (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    // Buffer heads
    input  commit_pkg::unit_results_t head_i,
    input  commit_pkg::unit_mask_t    empty_i,
    output commit_pkg::unit_mask_t    read_o,

    // Register file write port
    output logic                      wb_valid_o,
    output commit_pkg::writeback_t    wb_o
);

    // Tag of the oldest instruction not yet committed
    commit_pkg::rob_tag_t     expected_tag;

    // Head selected for commit in this cycle
    logic                     pop_valid;
    commit_pkg::exec_result_t pop_entry;

    // ====================
    // Head match
    // ====================

    // Tags are unique among live entries, so at most one head can match
    always_comb begin
        read_o    = '0;
        pop_valid = 1'b0;
        pop_entry = '0;
        for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
            if (!empty_i[u] && (head_i[u].ipacket.rob_tag == expected_tag) && !pop_valid) begin
                read_o[u] = 1'b1;
                pop_valid = 1'b1;
                pop_entry = head_i[u];
            end
        end
    end

    // ====================
    // Tag and write-back
    // ====================

    // The 6-bit tag wraps from 63 to 0 on its own
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            expected_tag <= '0;
            wb_valid_o   <= 1'b0;
        end else begin
            wb_valid_o <= pop_valid;
            if (pop_valid) begin
                expected_tag <= expected_tag + 1'b1;
            end
        end
    end

    // Write payload, qualified by wb_valid_o
    always_ff @(posedge clk_i) begin
        if (pop_valid) begin
            wb_o.reg_dest <= pop_entry.ipacket.reg_dest;
            wb_o.data     <= pop_entry.result;
        end
    end

endmodule : commit_arbiter

/* verilog/commit_stage.sv */
// ====================
// Commit stage top
// Dispatcher, one commit buffer per unit, forward selector and arbiter
// ====================

`timescale 1ns/100ps

module commit_stage (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,

    // Execution unit results
    input  commit_pkg::unit_mask_t    unit_valid_i,
    input  commit_pkg::unit_results_t unit_result_i,
    output commit_pkg::unit_mask_t    unit_stall_o,

    // Issue stage forwarding
    input  commit_pkg::src_addr_t     fwd_src_i,
    output commit_pkg::src_data_t     fwd_result_o,
    output commit_pkg::src_valid_t    fwd_valid_o,

    // Register file write
    output logic                      wb_valid_o,
    output commit_pkg::writeback_t    wb_o
);

    // Dispatcher to buffers
    commit_pkg::unit_mask_t      buf_write;
    commit_pkg::exec_result_t    dispatch_entry;
    commit_pkg::unit_mask_t      buf_invalidate;
    commit_pkg::reg_addr_t       invalid_reg;

    // Buffers to arbiter and dispatcher
    commit_pkg::unit_results_t   buf_head;
    commit_pkg::unit_mask_t      buf_read;
    commit_pkg::unit_mask_t      buf_full;
    commit_pkg::unit_mask_t      buf_empty;

    // Buffers to forward selector
    commit_pkg::unit_fwd_data_t  buf_fwd_result;
    commit_pkg::unit_fwd_valid_t buf_fwd_valid;

    result_dispatch u_dispatch (
        .unit_valid_i  (unit_valid_i),
        .unit_result_i (unit_result_i),
        .full_i        (buf_full),
        .unit_stall_o  (unit_stall_o),
        .write_o       (buf_write),
        .entry_o       (dispatch_entry),
        .invalidate_o  (buf_invalidate),
        .invalid_reg_o (invalid_reg)
    );

    // ====================
    // Buffers
    // ====================

    // One buffer per unit, all fed by the same dispatched entry
    for (genvar u = 0; u < commit_pkg::NUM_UNITS; u++) begin : g_buffer
        commit_buffer #(
            .BUFFER_DEPTH (commit_pkg::BUFFER_DEPTH)
        ) u_buffer (
            .clk_i            (clk_i),
            .rst_n_i          (rst_n_i),
            .flush_i          (flush_i),
            .write_i          (buf_write[u]),
            .read_i           (buf_read[u]),
            .entry_i          (dispatch_entry),
            .entry_o          (buf_head[u]),
            .invalidate_i     (buf_invalidate[u]),
            .invalid_reg_i    (invalid_reg),
            .forward_src_i    (fwd_src_i),
            .forward_result_o (buf_fwd_result[u]),
            .forward_valid_o  (buf_fwd_valid[u]),
            .full_o           (buf_full[u]),
            .empty_o          (buf_empty[u])
        );
    end : g_buffer

    forward_select u_forward (
        .buf_result_i (buf_fwd_result),
        .buf_valid_i  (buf_fwd_valid),
        .fwd_result_o (fwd_result_o),
        .fwd_valid_o  (fwd_valid_o)
    );

    commit_arbiter u_arbiter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .head_i     (buf_head),
        .empty_i    (buf_empty),
        .read_o     (buf_read),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

endmodule : commit_stage

/* tests/tb_commit_table.svh */
// ====================
// Commit stage stimulus table
// One row per cycle of unit results, flush and forwarding sources
// ====================

// add_row columns are the valid mask (bit n is unit n), then destination, tag and
// half-word data for units 0, 1 and 2, then flush and the two forwarding sources
task automatic build_table();
    int unit_a;
    int unit_b;

    // Units 1 and 2 together, then 0 and 2, so unit 2 waits two cycles
    add_row(3'b110, 0, 0, 'h0,    1, 1, 'h1101, 2, 2, 'h1202, 0, 1, 2);
    add_row(3'b101, 3, 0, 'h1003, 0, 0, 'h0,    2, 2, 'h1202, 0, 1, 0);
    add_row(3'b100, 0, 0, 'h0,    0, 0, 'h0,    2, 2, 'h1202, 0, 3, 2);
    add_row(3'b001, 4, 3, 'h1304, 0, 0, 'h0,    0, 0, 'h0,    0, 3, 2);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,    0, 0, 'h0,    0, 4, 1);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,    0, 0, 'h0,    0, 4, 2);

    // Register 5 written by unit 2 and then by unit 1 while tag 4 is still missing
    add_row(3'b100, 0, 0, 'h0,    0, 0, 'h0,    5, 5, 'h2505, 0, 5, 0);
    add_row(3'b010, 0, 0, 'h0,    5, 6, 'h2605, 0, 0, 'h0,    0, 5, 0);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,    0, 0, 'h0,    0, 5, 5);
    add_row(3'b001, 6, 4, 'h2406, 0, 0, 'h0,    0, 0, 'h0,    0, 5, 6);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,    0, 0, 'h0,    0, 5, 6);
    add_row(3'b001, 7, 7, 'h2707, 0, 0, 'h0,    0, 0, 'h0,    0, 5, 7);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,    0, 0, 'h0,    0, 5, 6);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,    0, 0, 'h0,    0, 5, 7);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,    0, 0, 'h0,    0, 7, 0);

    // Tag 8 withheld, unit 1 fills its buffer with tags 9 to 16 and stalls on 17
    add_row(3'b010, 0, 0, 'h0,    8, 9, 'h3109,   0, 0, 'h0, 0, 8, 0);
    add_row(3'b010, 0, 0, 'h0,    9, 10, 'h310a,  0, 0, 'h0, 0, 9, 8);
    add_row(3'b010, 0, 0, 'h0,    10, 11, 'h310b, 0, 0, 'h0, 0, 10, 8);
    add_row(3'b010, 0, 0, 'h0,    11, 12, 'h310c, 0, 0, 'h0, 0, 11, 8);
    add_row(3'b010, 0, 0, 'h0,    12, 13, 'h310d, 0, 0, 'h0, 0, 12, 8);
    add_row(3'b010, 0, 0, 'h0,    13, 14, 'h310e, 0, 0, 'h0, 0, 13, 8);
    add_row(3'b010, 0, 0, 'h0,    14, 15, 'h310f, 0, 0, 'h0, 0, 14, 8);
    add_row(3'b010, 0, 0, 'h0,    15, 16, 'h3110, 0, 0, 'h0, 0, 15, 8);
    add_row(3'b010, 0, 0, 'h0,    16, 17, 'h3111, 0, 0, 'h0, 0, 16, 8);
    add_row(3'b011, 17, 8, 'h3011, 16, 17, 'h3111, 0, 0, 'h0, 0, 17, 15);
    add_row(3'b010, 0, 0, 'h0,    16, 17, 'h3111, 0, 0, 'h0, 0, 17, 9);
    add_row(3'b010, 0, 0, 'h0,    16, 17, 'h3111, 0, 0, 'h0, 0, 8, 16);
    add_row(3'b010, 0, 0, 'h0,    16, 17, 'h3111, 0, 0, 'h0, 0, 9, 16);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,      0, 0, 'h0, 0, 16, 10);
    add_row(3'b000, 0, 0, 'h0,    0, 0, 'h0,      0, 0, 'h0, 0, 16, 0);

    // Tags 18 to 73 cross the wrap at 63, each pair arrives younger first
    for (int k = 18; k < 74; k += 2) begin
        unit_a = (k / 2) % commit_pkg::NUM_UNITS;
        unit_b = (unit_a + 1) % commit_pkg::NUM_UNITS;
        add_single(unit_a, ((k + 1) % 31) + 1, (k + 1) % 64, $random(seed),
                   ((k + 1) % 31) + 1, $random(seed) & 31);
        add_single(unit_b, (k % 31) + 1, k % 64, $random(seed),
                   (k % 31) + 1, ((k + 1) % 31) + 1);
        add_row(3'b000, 0, 0, 'h0, 0, 0, 'h0, 0, 0, 'h0, 0, $random(seed) & 31, 0);
    end

    // Tag 10 comes last and is due in the flush cycle, so the flush drops tags 10 to 12
    add_row(3'b001, 20, 11, 'h4014, 0, 0, 'h0,      0, 0, 'h0,      0, 20, 0);
    add_row(3'b100, 0, 0, 'h0,      0, 0, 'h0,      21, 12, 'h4215, 0, 20, 21);
    add_row(3'b010, 0, 0, 'h0,      24, 10, 'h4118, 0, 0, 'h0,      0, 20, 24);
    add_row(3'b000, 0, 0, 'h0,      0, 0, 'h0,      0, 0, 'h0,      1, 24, 21);
    add_row(3'b000, 0, 0, 'h0,      0, 0, 'h0,      0, 0, 'h0,      0, 24, 21);

    // Commit restarts at tag 0
    add_row(3'b100, 0, 0, 'h0, 0, 0, 'h0,       22, 1, 'h5216, 0, 22, 0);
    add_row(3'b010, 0, 0, 'h0, 23, 0, 'h5117,   0, 0, 'h0,     0, 22, 23);
    add_row(3'b000, 0, 0, 'h0, 0, 0, 'h0,       0, 0, 'h0,     0, 22, 23);
    add_row(3'b000, 0, 0, 'h0, 0, 0, 'h0,       0, 0, 'h0,     0, 23, 0);
endtask

/* tests/tb_commit_stage.sv */
// ====================
// Commit stage testbench
// Table driven stimulus checked against a reference model of the commit rules
// ====================

`timescale 1ns/100ps

module tb_commit_stage;

    localparam int DRAIN_LIMIT = 200;

    // One cycle of stimulus
    typedef struct packed {
        commit_pkg::unit_mask_t    valid;
        commit_pkg::unit_results_t res;
        logic                      flush;
        commit_pkg::src_addr_t     src;
    } row_t;

    logic                        clk_i;
    logic                        rst_n_i;
    logic                        flush_i;
    commit_pkg::unit_mask_t      unit_valid_i;
    commit_pkg::unit_results_t   unit_result_i;
    commit_pkg::unit_mask_t      unit_stall_o;
    commit_pkg::src_addr_t       fwd_src_i;
    commit_pkg::src_data_t       fwd_result_o;
    commit_pkg::src_valid_t      fwd_valid_o;
    logic                        wb_valid_o;
    commit_pkg::writeback_t      wb_o;

    row_t                        table_q [$];
    integer                      seed;
    int                          errors;
    int                          checks;

    // ====================
    // Reference model
    // ====================

    // Uncommitted results per unit buffer and the next tag to commit
    commit_pkg::exec_result_t    model_q [commit_pkg::NUM_UNITS][$];
    commit_pkg::rob_tag_t        expected_tag;
    logic                        wb_valid_q;
    commit_pkg::writeback_t      wb_q;

    // Newest uncommitted value per register and the tag that owns it
    commit_pkg::data_word_t      reg_value [commit_pkg::NUM_REGS];
    commit_pkg::rob_tag_t        reg_owner [commit_pkg::NUM_REGS];
    logic [commit_pkg::NUM_REGS-1:0] reg_valid;

    commit_stage u_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .unit_valid_i  (unit_valid_i),
        .unit_result_i (unit_result_i),
        .unit_stall_o  (unit_stall_o),
        .fwd_src_i     (fwd_src_i),
        .fwd_result_o  (fwd_result_o),
        .fwd_valid_o   (fwd_valid_o),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    function automatic commit_pkg::exec_result_t make_result(input int dest, input int tag,
                                                             input commit_pkg::data_word_t data);
        commit_pkg::exec_result_t res;
        res.result           = data;
        res.ipacket.reg_dest = commit_pkg::reg_addr_t'(dest);
        res.ipacket.rob_tag  = commit_pkg::rob_tag_t'(tag);
        return res;
    endfunction

    // Half-word table data fills the whole word, upper half plain and lower half inverted
    function automatic commit_pkg::data_word_t spread(input int v);
        return {v[15:0], ~v[15:0]};
    endfunction

    task automatic add_row(input commit_pkg::unit_mask_t valid,
                           input int d0, input int t0, input int v0,
                           input int d1, input int t1, input int v1,
                           input int d2, input int t2, input int v2,
                           input int flush, input int s0, input int s1);
        row_t row;
        row.valid  = valid;
        row.res[0] = make_result(d0, t0, spread(v0));
        row.res[1] = make_result(d1, t1, spread(v1));
        row.res[2] = make_result(d2, t2, spread(v2));
        row.flush  = flush[0];
        row.src[0] = commit_pkg::reg_addr_t'(s0);
        row.src[1] = commit_pkg::reg_addr_t'(s1);
        table_q.push_back(row);
    endtask

    // Row with a single valid unit and a full-width data word
    task automatic add_single(input int unit, input int dest, input int tag,
                              input commit_pkg::data_word_t data, input int s0, input int s1);
        row_t row;
        row             = '0;
        row.valid[unit] = 1'b1;
        row.res[unit]   = make_result(dest, tag, data);
        row.src[0]      = commit_pkg::reg_addr_t'(s0);
        row.src[1]      = commit_pkg::reg_addr_t'(s1);
        table_q.push_back(row);
    endtask

    `include "tb_commit_table.svh"

    function automatic int pending_count();
        int total;
        total = 0;
        for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
            total += model_q[u].size();
        end
        return total;
    endfunction

    // ====================
    // One cycle
    // ====================

    // Drives a row, checks the DUT mid-cycle and then moves the model past the next edge
    task automatic step_cycle(input row_t row);
        commit_pkg::unit_mask_t   full;
        commit_pkg::unit_mask_t   stall;
        logic                     take;
        int                       take_unit;
        logic                     pop;
        int                       pop_unit;
        commit_pkg::exec_result_t entry;
        commit_pkg::reg_addr_t    src;

        @(posedge clk_i);
        unit_valid_i  <= row.valid;
        unit_result_i <= row.res;
        flush_i       <= row.flush;
        fwd_src_i     <= row.src;
        @(negedge clk_i);

        // The lowest valid unit with room in its buffer is taken, every other one waits
        take      = 1'b0;
        take_unit = 0;
        for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
            full[u] = (model_q[u].size() == commit_pkg::BUFFER_DEPTH);
            if (row.valid[u] && !full[u] && !take) begin
                take      = 1'b1;
                take_unit = u;
            end
        end
        for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
            stall[u] = full[u] || (row.valid[u] && !(take && take_unit == u));
        end
        check_value("unit_stall_o", 32'(stall), 32'(unit_stall_o));

        // Write-back shows the commit of the previous cycle
        check_value("wb_valid_o", 32'(wb_valid_q), 32'(wb_valid_o));
        if (wb_valid_q) begin
            check_value("wb_o.reg_dest", 32'(wb_q.reg_dest), 32'(wb_o.reg_dest));
            check_value("wb_o.data", wb_q.data, wb_o.data);
        end

        for (int s = 0; s < commit_pkg::NUM_SRC; s++) begin
            src = row.src[s];
            if (src == '0) begin
                check_value($sformatf("fwd_valid_o[%0d]", s), 32'd1, 32'(fwd_valid_o[s]));
                check_value($sformatf("fwd_result_o[%0d]", s), 32'd0, fwd_result_o[s]);
            end else begin
                check_value($sformatf("fwd_valid_o[%0d]", s), 32'(reg_valid[src]),
                            32'(fwd_valid_o[s]));
                if (reg_valid[src]) begin
                    check_value($sformatf("fwd_result_o[%0d]", s), reg_value[src],
                                fwd_result_o[s]);
                end
            end
        end

        if (row.flush) begin
            for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
                model_q[u].delete();
            end
            reg_valid    = '0;
            expected_tag = '0;
            wb_valid_q   = 1'b0;
        end else begin
            // Commit the head that carries the expected tag, if any
            pop      = 1'b0;
            pop_unit = 0;
            for (int u = 0; u < commit_pkg::NUM_UNITS; u++) begin
                if (!pop && model_q[u].size() > 0
                        && model_q[u][0].ipacket.rob_tag == expected_tag) begin
                    pop      = 1'b1;
                    pop_unit = u;
                end
            end
            wb_valid_q = pop;
            if (pop) begin
                entry         = model_q[pop_unit].pop_front();
                wb_q.reg_dest = entry.ipacket.reg_dest;
                wb_q.data     = entry.result;
                expected_tag  = commit_pkg::rob_tag_t'(expected_tag + 1);
                if (reg_owner[entry.ipacket.reg_dest] == entry.ipacket.rob_tag) begin
                    reg_valid[entry.ipacket.reg_dest] = 1'b0;
                end
            end
            // A result taken now is newer than anything committed in the same cycle
            if (take) begin
                entry = row.res[take_unit];
                model_q[take_unit].push_back(entry);
                reg_value[entry.ipacket.reg_dest] = entry.result;
                reg_owner[entry.ipacket.reg_dest] = entry.ipacket.rob_tag;
                reg_valid[entry.ipacket.reg_dest] = 1'b1;
            end
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        int cycles;

        seed          = 8;
        errors        = 0;
        checks        = 0;
        expected_tag  = '0;
        wb_valid_q    = 1'b0;
        wb_q          = '0;
        reg_valid     = '0;
        rst_n_i      <= 1'b0;
        flush_i      <= 1'b0;
        unit_valid_i <= '0;
        unit_result_i <= '0;
        fwd_src_i    <= '0;
        build_table();

        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("wb_valid_o", 32'd0, 32'(wb_valid_o));
        check_value("unit_stall_o", 32'd0, 32'(unit_stall_o));

        for (int i = 0; i < table_q.size(); i++) begin
            step_cycle(table_q[i]);
        end

        // Idle until every result taken has been written back
        cycles = 0;
        while ((pending_count() > 0 || wb_valid_q) && cycles < DRAIN_LIMIT) begin
            step_cycle('0);
            cycles++;
        end
        if (pending_count() > 0 || wb_valid_q) begin
            $display("Timeout: %0d results never reached write-back", pending_count());
            errors++;
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_commit_stage

/* verilog.f */
+incdir+tests
verilog/commit_pkg.sv
verilog/commit_buffer.sv
verilog/result_dispatch.sv
verilog/forward_select.sv
verilog/commit_arbiter.sv
verilog/commit_stage.sv
tests/tb_commit_stage.sv

/* Makefile */
# Verilator build and run of the commit stage testbench

TOP := tb_commit_stage
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir $(OBJ)

# The run passes only if the log holds the pass line
run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf $(OBJ) sim.log
